/* alu.sv */
`timescale 1ns/1ps

`include "exec_settings.svh"

module alu (
    input  logic                   clk,
    input  logic                   reset,
    input  arch_defs_pkg::data_t   in_one,
    input  arch_defs_pkg::data_t   in_two,
    input  logic                   in_carry,
    input  arch_defs_pkg::alu_op_t alu_op,
    output arch_defs_pkg::data_t   latched_result,
    output logic                   zero_flag,
    output logic                   carry_flag,
    output logic                   negative_flag
);
    import arch_defs_pkg::*;

    localparam int DW = `EXEC_DATA_WIDTH;

    logic [DW:0] arith_sum;    // Extra bit keeps the carry-out
    logic [DW:0] cin_ext;
    logic [DW:0] one_ext;
    data_t       logic_res;
    data_t       final_res;
    logic        carry_out;

    assign cin_ext = {{DW{1'b0}}, in_carry};
    assign one_ext = {{DW{1'b0}}, 1'b1};

    always_comb begin
        arith_sum = '0;
        logic_res = '0;
        case (alu_op)
            ALU_ADD: arith_sum = {1'b0, in_one} + {1'b0, in_two};
            ALU_ADC: arith_sum = {1'b0, in_one} + {1'b0, in_two} + cin_ext;
            ALU_SUB: arith_sum = {1'b0, in_one} + {1'b0, ~in_two} + one_ext;    // Two's complement
            ALU_SBC: arith_sum = {1'b0, in_one} + {1'b0, ~in_two} + cin_ext;    // Carry means no borrow
            ALU_INR: arith_sum = {1'b0, in_one} + one_ext;
            ALU_DCR: arith_sum = {1'b0, in_one} + {1'b0, ~data_t'(1)} + one_ext;
            ALU_AND: logic_res = in_one & in_two;
            ALU_OR:  logic_res = in_one | in_two;
            ALU_XOR: logic_res = in_one ^ in_two;
            default: logic_res = '0;
        endcase

        case (alu_op)
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_INR, ALU_DCR: begin
                carry_out = arith_sum[DW];    // Carry-out of the extra bit
                final_res = arith_sum[DW-1:0];
            end
            default: begin
                carry_out = 1'b0;    // Logic ops clear carry
                final_res = logic_res;
            end
        endcase
    end

    assign carry_flag    = carry_out;
    assign zero_flag     = (final_res == '0);
    assign negative_flag = final_res[DW-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            latched_result <= '0;
        end else begin
            latched_result <= final_res;    // Only the result is registered
        end
    end

    // Control never issues an undefined operation code
    assert property (@(posedge clk) disable iff (reset)
        alu_op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_INR,
                       ALU_DCR, ALU_AND, ALU_OR, ALU_XOR});

endmodule

/* arch_defs_pkg.sv */
`include "exec_settings.svh"

package arch_defs_pkg;

    // One operand or result word
    typedef logic [`EXEC_DATA_WIDTH-1:0] data_t;

    // Register index
    typedef logic [$clog2(`EXEC_REG_COUNT)-1:0] reg_addr_t;

    // ALU operation codes with 9 to 15 unused
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,    // A + B
        ALU_ADC = 4'd1,    // A + B + carry
        ALU_SUB = 4'd2,    // A - B with carry set on no borrow
        ALU_SBC = 4'd3,    // A + ~B + carry
        ALU_INR = 4'd4,    // A + 1
        ALU_DCR = 4'd5,    // A - 1
        ALU_AND = 4'd6,
        ALU_OR  = 4'd7,
        ALU_XOR = 4'd8
    } alu_op_t;

endpackage

/* exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_valid_i,
    input  arch_defs_pkg::alu_op_t   instr_op_i,
    input  arch_defs_pkg::reg_addr_t instr_dst_i,
    input  arch_defs_pkg::reg_addr_t instr_src_a_i,
    input  arch_defs_pkg::reg_addr_t instr_src_b_i,
    input  arch_defs_pkg::data_t     instr_imm_i,
    input  logic                     instr_use_imm_i,
    reg_bus_if.ctrl_mp               bus,
    output arch_defs_pkg::data_t     alu_a_o,
    output arch_defs_pkg::data_t     alu_b_o,
    output logic                     alu_carry_o,
    output arch_defs_pkg::alu_op_t   alu_op_o,
    input  arch_defs_pkg::data_t     alu_result_i,
    input  logic                     alu_zero_i,
    input  logic                     alu_carry_i,
    input  logic                     alu_negative_i,
    output logic                     busy_o,
    output logic                     done_o,
    output exec_ctrl_pkg::flags_t    flags_o,
    output arch_defs_pkg::data_t     result_o
);
    import arch_defs_pkg::*;
    import exec_ctrl_pkg::*;

    exec_state_t state_q;
    exec_state_t state_d;
    alu_op_t     op_q;
    reg_addr_t   dst_q;
    reg_addr_t   src_a_q;
    reg_addr_t   src_b_q;
    data_t       imm_q;
    logic        use_imm_q;
    flags_t      flags_q;
    logic        accept;

    // Strobes while busy are dropped
    assign accept = instr_valid_i && (state_q == ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_READ;
                end
            end
            ST_READ:  state_d = ST_EXEC;     // Read data registered at this edge
            ST_EXEC:  state_d = ST_WRITE;    // ALU latches, flags captured
            ST_WRITE: state_d = ST_IDLE;     // Register written
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            op_q      <= ALU_ADD;
            dst_q     <= '0;
            src_a_q   <= '0;
            src_b_q   <= '0;
            imm_q     <= '0;
            use_imm_q <= 1'b0;
            flags_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                op_q      <= instr_op_i;
                dst_q     <= instr_dst_i;
                src_a_q   <= instr_src_a_i;
                src_b_q   <= instr_src_b_i;
                imm_q     <= instr_imm_i;
                use_imm_q <= instr_use_imm_i;
            end
            if (state_q == ST_EXEC) begin
                flags_q[FLAG_NEG]   <= alu_negative_i;
                flags_q[FLAG_ZERO]  <= alu_zero_i;
                flags_q[FLAG_CARRY] <= alu_carry_i;
            end
        end
    end

    assign bus.rd_addr_a = src_a_q;
    assign bus.rd_addr_b = src_b_q;
    assign bus.wr_en     = (state_q == ST_WRITE);
    assign bus.wr_addr   = dst_q;
    assign bus.wr_data   = alu_result_i;    // Latched ALU result

    assign alu_a_o     = bus.rd_data_a;
    assign alu_b_o     = use_imm_q ? imm_q : bus.rd_data_b;    // Immediate replaces B
    assign alu_carry_o = flags_q[FLAG_CARRY];                 // Carry feedback
    assign alu_op_o    = op_q;

    assign busy_o   = (state_q != ST_IDLE);
    assign done_o   = (state_q == ST_WRITE);
    assign flags_o  = flags_q;
    assign result_o = alu_result_i;

    // Done is a single-cycle pulse per instruction
    assert property (@(posedge clk) disable iff (reset) done_o |=> !done_o);

    // Every write back belongs to an instruction accepted three edges earlier
    assert property (@(posedge clk) disable iff (reset)
        bus.wr_en |-> $past(accept, 3));

endmodule

/* exec_ctrl_pkg.sv */
package exec_ctrl_pkg;

    // Sequencer states for one instruction in flight
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // Waiting for a strobe
        ST_READ  = 2'd1,    // Register file read in progress
        ST_EXEC  = 2'd2,    // ALU computing
        ST_WRITE = 2'd3     // Write back and done pulse
    } exec_state_t;

    // Negative, zero and carry from high bit to low
    typedef logic [2:0] flags_t;

    localparam int FLAG_NEG   = 2;
    localparam int FLAG_ZERO  = 1;
    localparam int FLAG_CARRY = 0;

endpackage

/* exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Width of one operand or result word
`define EXEC_DATA_WIDTH 8

// Number of general purpose registers
`define EXEC_REG_COUNT 4

`endif

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_valid_i,
    input  arch_defs_pkg::alu_op_t   instr_op_i,
    input  arch_defs_pkg::reg_addr_t instr_dst_i,
    input  arch_defs_pkg::reg_addr_t instr_src_a_i,
    input  arch_defs_pkg::reg_addr_t instr_src_b_i,
    input  arch_defs_pkg::data_t     instr_imm_i,
    input  logic                     instr_use_imm_i,
    output logic                     busy_o,
    output logic                     done_o,
    output arch_defs_pkg::data_t     result_o,
    output logic                     zero_o,
    output logic                     carry_o,
    output logic                     negative_o
);
    import arch_defs_pkg::*;
    import exec_ctrl_pkg::*;

    data_t   alu_a;
    data_t   alu_b;
    logic    alu_cin;
    alu_op_t alu_op;
    data_t   alu_result;
    logic    alu_zero;
    logic    alu_carry;
    logic    alu_negative;
    flags_t  flags;

    reg_bus_if u_bus ();

    exec_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .instr_valid_i   (instr_valid_i),
        .instr_op_i      (instr_op_i),
        .instr_dst_i     (instr_dst_i),
        .instr_src_a_i   (instr_src_a_i),
        .instr_src_b_i   (instr_src_b_i),
        .instr_imm_i     (instr_imm_i),
        .instr_use_imm_i (instr_use_imm_i),
        .bus             (u_bus.ctrl_mp),
        .alu_a_o         (alu_a),
        .alu_b_o         (alu_b),
        .alu_carry_o     (alu_cin),
        .alu_op_o        (alu_op),
        .alu_result_i    (alu_result),
        .alu_zero_i      (alu_zero),
        .alu_carry_i     (alu_carry),
        .alu_negative_i  (alu_negative),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .flags_o         (flags),
        .result_o        (result_o)
    );

    reg_file u_rf (
        .clk   (clk),
        .reset (reset),
        .bus   (u_bus.rf_mp)
    );

    alu u_alu (
        .clk            (clk),
        .reset          (reset),
        .in_one         (alu_a),
        .in_two         (alu_b),
        .in_carry       (alu_cin),
        .alu_op         (alu_op),
        .latched_result (alu_result),
        .zero_flag      (alu_zero),
        .carry_flag     (alu_carry),
        .negative_flag  (alu_negative)
    );

    assign zero_o     = flags[FLAG_ZERO];     // Split from the flag register
    assign carry_o    = flags[FLAG_CARRY];
    assign negative_o = flags[FLAG_NEG];

endmodule

/* reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if;
    import arch_defs_pkg::*;

    reg_addr_t rd_addr_a;    // Read port A address
    reg_addr_t rd_addr_b;    // Read port B address
    data_t     rd_data_a;    // Registered read data A
    data_t     rd_data_b;    // Registered read data B
    logic      wr_en;
    reg_addr_t wr_addr;
    data_t     wr_data;

    modport ctrl_mp (
        output rd_addr_a, rd_addr_b,
        output wr_en, wr_addr, wr_data,
        input  rd_data_a, rd_data_b
    );

    modport rf_mp (
        input  rd_addr_a, rd_addr_b,
        input  wr_en, wr_addr, wr_data,
        output rd_data_a, rd_data_b
    );

endinterface

/* reg_file.sv */
`timescale 1ns/1ps

`include "exec_settings.svh"

module reg_file (
    input logic      clk,
    input logic      reset,
    reg_bus_if.rf_mp bus
);
    import arch_defs_pkg::*;

    data_t regs [`EXEC_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            bus.rd_data_a <= '0;
            bus.rd_data_b <= '0;
        end else begin
            if (bus.wr_en) begin
                regs[bus.wr_addr] <= bus.wr_data;    // Lands on this edge
            end
            // Same-cycle read of the written register sees the old value
            bus.rd_data_a <= regs[bus.rd_addr_a];
            bus.rd_data_b <= regs[bus.rd_addr_b];
        end
    end

    // The sequencer must present a clean destination with every write
    assert property (@(posedge clk) disable iff (reset)
        bus.wr_en |-> !$isunknown(bus.wr_addr));

endmodule

/* sim.f */
+incdir+.
arch_defs_pkg.sv
exec_ctrl_pkg.sv
reg_bus_if.sv
alu.sv
reg_file.sv
exec_ctrl.sv
exec_unit.sv
tb_exec_unit.sv

/* tb_exec_unit.sv */
`timescale 1ns/1ps

`include "exec_settings.svh"

module tb_exec_unit;
    import arch_defs_pkg::*;
    import exec_ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int DONE_LATENCY   = 3;    // Strobe cycle to done pulse
    localparam int MAX_WORD       = (1 << `EXEC_DATA_WIDTH) - 1;

    logic      clk = 1'b0;
    logic      reset;
    logic      instr_valid_i;
    alu_op_t   instr_op_i;
    reg_addr_t instr_dst_i;
    reg_addr_t instr_src_a_i;
    reg_addr_t instr_src_b_i;
    data_t     instr_imm_i;
    logic      instr_use_imm_i;
    logic      busy_o;
    logic      done_o;
    data_t     result_o;
    logic      zero_o;
    logic      carry_o;
    logic      negative_o;

    integer    seed;
    data_t     model_regs [`EXEC_REG_COUNT];
    logic      model_carry;
    data_t     exp_res_q [$];     // Expected results in issue order
    flags_t    exp_flags_q [$];

    exec_unit u_exec_unit (.*);

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input flags_t exp, input flags_t act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    // Expected result and flags straight from the ALU rules
    function automatic void ref_exec(input alu_op_t op, input data_t a, input data_t b,
                                     input logic cin, output data_t res, output flags_t fl);
        int   full;
        logic carry;
        case (op)
            ALU_ADD: full = int'(a) + int'(b);
            ALU_ADC: full = int'(a) + int'(b) + int'(cin);
            ALU_SUB: full = int'(a) - int'(b);
            ALU_SBC: full = int'(a) - int'(b) - (cin ? 0 : 1);
            ALU_INR: full = int'(a) + 1;
            ALU_DCR: full = int'(a) - 1;
            ALU_AND: full = int'(a & b);
            ALU_OR:  full = int'(a | b);
            ALU_XOR: full = int'(a ^ b);
            default: full = 0;
        endcase
        // Subtractions report no borrow as carry
        case (op)
            ALU_ADD, ALU_ADC, ALU_INR: carry = (full > MAX_WORD);
            ALU_SUB, ALU_SBC, ALU_DCR: carry = (full >= 0);
            default:                   carry = 1'b0;
        endcase
        res = data_t'(full);
        fl  = {res[`EXEC_DATA_WIDTH-1], (res == '0), carry};
    endfunction

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy_o !== 1'b0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure("Timed out waiting for busy_o to fall");
            end
        end
    endtask

    // Issues one instruction with an optional second strobe while busy
    task automatic issue(input alu_op_t op, input reg_addr_t dst, input reg_addr_t src_a,
                         input reg_addr_t src_b, input data_t imm, input logic use_imm,
                         input logic send_drop);
        data_t  b_val;
        data_t  exp_res;
        flags_t exp_flags;
        int     cycles;
        wait_idle();
        b_val = use_imm ? imm : model_regs[src_b];
        ref_exec(op, model_regs[src_a], b_val, model_carry, exp_res, exp_flags);
        exp_res_q.push_back(exp_res);
        exp_flags_q.push_back(exp_flags);
        model_regs[dst] = exp_res;
        model_carry     = exp_flags[FLAG_CARRY];
        instr_valid_i   = 1'b1;
        instr_op_i      = op;
        instr_dst_i     = dst;
        instr_src_a_i   = src_a;
        instr_src_b_i   = src_b;
        instr_imm_i     = imm;
        instr_use_imm_i = use_imm;
        cycles = 0;
        while (done_o !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles == 1) begin
                check_bit("busy_o", 1'b1, busy_o);
                instr_valid_i = send_drop;
                instr_op_i    = ALU_XOR;     // Must never reach the ALU
                instr_imm_i   = 8'hA5;
            end else begin
                instr_valid_i = 1'b0;
            end
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure("Timed out waiting for done_o");
            end
        end
        if (cycles != DONE_LATENCY) begin
            report_failure($sformatf("done_o arrived %0d cycles after the strobe", cycles));
        end
        @(posedge clk);
        #1;
        check_bit("done_o", 1'b0, done_o);    // One-cycle pulse
    endtask

    task automatic load_reg(input reg_addr_t dst, input data_t val);
        issue(ALU_AND, dst, dst, 2'd0, 8'h00, 1'b1, 1'b0);
        issue(ALU_OR, dst, dst, 2'd0, val, 1'b1, 1'b0);
    endtask

    // Compare on the falling edge where result and flags are stable
    always @(negedge clk) begin
        if (!reset && done_o) begin
            if (exp_res_q.size() == 0) begin
                report_failure("done_o pulsed with no instruction outstanding");
            end else begin
                check_data("result_o", exp_res_q.pop_front(), result_o);
                check_flags("flags", exp_flags_q.pop_front(), {negative_o, zero_o, carry_o});
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        seed            = 32'h6481;
        reset           = 1'b1;
        instr_valid_i   = 1'b0;
        instr_op_i      = ALU_ADD;
        instr_dst_i     = '0;
        instr_src_a_i   = '0;
        instr_src_b_i   = '0;
        instr_imm_i     = '0;
        instr_use_imm_i = 1'b0;
        model_carry     = 1'b0;
        for (int r = 0; r < `EXEC_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        check_bit("busy_o", 1'b0, busy_o);
        check_bit("done_o", 1'b0, done_o);
        issue(ALU_SUB, 2'd0, 2'd0, 2'd0, 8'h00, 1'b0, 1'b0);    // Zero with no borrow

        for (int r = 0; r < `EXEC_REG_COUNT; r++) begin
            issue(ALU_OR, reg_addr_t'(r), reg_addr_t'(r), 2'd0, data_t'(8'h31 * (r + 1)),
                  1'b1, 1'b0);
        end
        for (int r = 0; r < `EXEC_REG_COUNT; r++) begin
            issue(ALU_ADD, reg_addr_t'(r), reg_addr_t'(r), 2'd0, 8'h00, 1'b1, 1'b0);
        end

        // Carry chains
        for (int r = 0; r < `EXEC_REG_COUNT; r++) begin
            rnd = $random(seed);
            load_reg(reg_addr_t'(r), rnd[7:0]);
        end
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            issue(rnd[0] ? ALU_ADC : ALU_SBC, rnd[2:1], rnd[4:3], rnd[6:5], 8'h00, 1'b0, 1'b0);
        end
        load_reg(2'd0, 8'h10);
        load_reg(2'd1, 8'h80);
        issue(ALU_SBC, 2'd2, 2'd0, 2'd1, 8'h00, 1'b0, 1'b0);    // A below B gives a borrow
        issue(ALU_SBC, 2'd3, 2'd1, 2'd0, 8'h00, 1'b0, 1'b0);

        // Corner cases
        load_reg(2'd0, 8'hFF);
        issue(ALU_INR, 2'd1, 2'd0, 2'd0, 8'h00, 1'b0, 1'b0);
        issue(ALU_AND, 2'd2, 2'd0, 2'd0, 8'h0F, 1'b1, 1'b0);
        issue(ALU_INR, 2'd1, 2'd0, 2'd0, 8'h00, 1'b0, 1'b0);
        issue(ALU_OR, 2'd2, 2'd0, 2'd0, 8'h00, 1'b1, 1'b0);
        issue(ALU_INR, 2'd1, 2'd0, 2'd0, 8'h00, 1'b0, 1'b0);
        issue(ALU_XOR, 2'd2, 2'd0, 2'd0, 8'h5A, 1'b1, 1'b0);
        load_reg(2'd3, 8'h00);
        issue(ALU_INR, 2'd1, 2'd0, 2'd0, 8'h00, 1'b0, 1'b0);    // Sets carry before the decrement
        issue(ALU_DCR, 2'd3, 2'd3, 2'd0, 8'h00, 1'b0, 1'b0);

        // Strobe while busy must be dropped
        issue(ALU_ADD, 2'd1, 2'd2, 2'd3, 8'h00, 1'b0, 1'b1);
        for (int r = 0; r < `EXEC_REG_COUNT; r++) begin
            issue(ALU_ADD, reg_addr_t'(r), reg_addr_t'(r), 2'd0, 8'h00, 1'b1, 1'b0);
        end

        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            issue(alu_op_t'(rnd % 9), rnd[5:4], rnd[7:6], rnd[9:8], rnd[17:10], rnd[18],
                  1'b0);
        end

        @(posedge clk);
        #1;
        if (exp_res_q.size() != 0) begin
            report_failure("Some expected results were never compared");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule
